/* sim.f */
src/cpu_isa_pkg.sv
src/cpu_pipe_pkg.sv
src/alu.sv
src/reg_file.sv
src/fetch_stage.sv
src/decode_unit.sv
src/hazard_unit.sv
src/cpu_top.sv
tests/tb_cpu.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_cpu
FILELIST := sim.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tests/tb_cpu.sv */
module tb_cpu;

    localparam int CLK_HALF      = 10;
    localparam int DRIVE_DLY     = 2;
    localparam int STORE_TIMEOUT = 200;  // cycles allowed per store
    localparam int QUIET_CYCLES  = 60;
    localparam int ROM_WORDS     = 64;
    localparam int DMEM_WORDS    = 1 << cpu_pipe_pkg::DMEM_AW;

    logic                             clk;
    logic                             rstn;
    logic [cpu_pipe_pkg::XLEN-1:0]    imem_addr;
    logic [cpu_pipe_pkg::XLEN-1:0]    imem_data;
    logic [cpu_pipe_pkg::DMEM_AW-1:0] dmem_addr;
    logic [cpu_pipe_pkg::XLEN-1:0]    dmem_wdata;
    logic                             dmem_we;
    logic [cpu_pipe_pkg::XLEN-1:0]    dmem_rdata;

    logic [cpu_pipe_pkg::XLEN-1:0]    rom  [ROM_WORDS];
    logic [cpu_pipe_pkg::XLEN-1:0]    dmem [DMEM_WORDS];
    logic [cpu_pipe_pkg::XLEN-3:0]    fetch_idx;

    // expected stores, in program order
    string                            exp_name [$];
    int unsigned                      exp_addr [$];
    logic [cpu_pipe_pkg::XLEN-1:0]    exp_data [$];

    cpu_top UUT (
        .clk(clk),
        .rstn(rstn),
        .imem_addr_o(imem_addr),
        .imem_data_i(imem_data),
        .dmem_addr_o(dmem_addr),
        .dmem_wdata_o(dmem_wdata),
        .dmem_we_o(dmem_we),
        .dmem_rdata_i(dmem_rdata)
    );

    always #(CLK_HALF) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // memory models
    ////////////////////////////////////////////////////////////
    assign fetch_idx = imem_addr[cpu_pipe_pkg::XLEN-1:2];
    assign imem_data = (fetch_idx < 30'(ROM_WORDS)) ? rom[fetch_idx[5:0]] : '0;
    assign dmem_rdata = dmem[dmem_addr];  // same-cycle read

    always @(posedge clk)
    begin
        if (dmem_we)
            dmem[dmem_addr] <= dmem_wdata;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
            stop_with_failure($sformatf("FAIL %s: expected %h, actual %h",
                                        name, expected, actual));
    endtask

    task automatic add_store(input string name, input int unsigned addr,
                             input logic [31:0] data);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic wait_for_store(input string name);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!dmem_we && cycles < STORE_TIMEOUT);
        if (!dmem_we)
            stop_with_failure($sformatf("timeout: store %s never reached the data memory",
                                        name));
    endtask

    task automatic fill_data_memory();
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] = 32'hd00d_0000 + 32'(i);  // contents follow the word address
    endtask

    task automatic load_program();
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i] = '0;
        rom[0]  = 32'h00500093;  // addi x1, x0, 5
        rom[1]  = 32'h00708113;  // addi x2, x1, 7
        rom[2]  = 32'h002081b3;  // add  x3, x1, x2
        rom[3]  = 32'h0ff1c213;  // xori x4, x3, 0xff
        rom[4]  = 32'h401202b3;  // sub  x5, x4, x1
        rom[5]  = 32'h0022e333;  // or   x6, x5, x2
        rom[6]  = 32'h004373b3;  // and  x7, x6, x4
        rom[7]  = 32'h00139433;  // sll  x8, x7, x1
        rom[8]  = 32'h00802023;  // sw   x8, 0(x0)
        rom[9]  = 32'h00502223;  // sw   x5, 4(x0)
        rom[10] = 32'h0f037493;  // andi x9, x6, 0xf0
        rom[11] = 32'h0034e513;  // ori  x10, x9, 3
        rom[12] = 32'h00a02423;  // sw   x10, 8(x0)
        rom[13] = 32'h04302023;  // sw   x3, 64(x0)
        rom[14] = 32'h04002583;  // lw   x11, 64(x0)
        rom[15] = 32'h00658633;  // add  x12, x11, x6   load-use
        rom[16] = 32'h00c02623;  // sw   x12, 12(x0)
        rom[17] = 32'h08002683;  // lw   x13, 128(x0)   preset word
        rom[18] = 32'h00168713;  // addi x14, x13, 1
        rom[19] = 32'h00e02823;  // sw   x14, 16(x0)
        rom[20] = 32'hffd00793;  // addi x15, x0, -3
        rom[21] = 32'h0017c463;  // blt  x15, x1, +8    taken
        rom[22] = 32'h00002a23;  // sw   x0, 20(x0)     skipped
        rom[23] = 32'h0017d463;  // bge  x15, x1, +8    not taken
        rom[24] = 32'h00102c23;  // sw   x1, 24(x0)
        rom[25] = 32'h00208463;  // beq  x1, x2, +8     not taken
        rom[26] = 32'h00202e23;  // sw   x2, 28(x0)
        rom[27] = 32'h04002803;  // lw   x16, 64(x0)
        rom[28] = 32'h00381463;  // bne  x16, x3, +8    not taken, load ahead
        rom[29] = 32'h03002023;  // sw   x16, 32(x0)
        rom[30] = 32'h00380463;  // beq  x16, x3, +8    taken
        rom[31] = 32'h02002223;  // sw   x0, 36(x0)     skipped
        rom[32] = 32'h00f0d463;  // bge  x1, x15, +8    taken
        rom[33] = 32'h02002423;  // sw   x0, 40(x0)     skipped
        rom[34] = 32'h00209463;  // bne  x1, x2, +8     taken
        rom[35] = 32'h02002623;  // sw   x0, 44(x0)     skipped
        rom[36] = 32'h00114463;  // blt  x2, x1, +8     not taken
        rom[37] = 32'h02f02823;  // sw   x15, 48(x0)
        rom[38] = 32'hfc000893;  // addi x17, x0, -64
        rom[39] = 32'h00400913;  // addi x18, x0, 4
        rom[40] = 32'h4128d9b3;  // sra  x19, x17, x18
        rom[41] = 32'h0128da33;  // srl  x20, x17, x18
        rom[42] = 32'h41190ab3;  // sub  x21, x18, x17
        rom[43] = 32'h03302a23;  // sw   x19, 52(x0)
        rom[44] = 32'h03402c23;  // sw   x20, 56(x0)
        rom[45] = 32'h03502e23;  // sw   x21, 60(x0)
        rom[46] = 32'h00000063;  // beq  x0, x0, 0      park here
    endtask

    task automatic load_expected();
        add_store("chain_sll",         0,  32'h0000_1d80);
        add_store("chain_sub",         1,  32'h0000_00e9);
        add_store("chain_ori",         2,  32'h0000_00e3);
        add_store("store_before_load", 16, 32'h0000_0011);
        add_store("load_use_add",      3,  32'h0000_00fe);
        add_store("load_preset_word",  4,  32'hd00d_0021);
        add_store("bge_not_taken",     6,  32'h0000_0005);
        add_store("beq_not_taken",     7,  32'h0000_000c);
        add_store("bne_after_load",    8,  32'h0000_0011);
        add_store("blt_not_taken",     12, 32'hffff_fffd);
        add_store("sra_negative",      13, 32'hffff_fffc);
        add_store("srl_negative",      14, 32'h0fff_fffc);
        add_store("sub_negative",      15, 32'h0000_0044);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        clk  = 1'b0;
        rstn = 1'b0;
        load_program();
        fill_data_memory();
        load_expected();

        repeat (3)
        begin
            @(posedge clk);
            #(DRIVE_DLY);
            check_value("reset_we", 32'h0, 32'(dmem_we));
            check_value("reset_pc", 32'h0000_0000, imem_addr);
        end
        rstn = 1'b1;  // released just after the third edge

        @(negedge clk);
        check_value("first_fetch_pc", 32'h0000_0000, imem_addr);
        repeat (3)
        begin
            @(negedge clk);
            check_value("early_we", 32'h0, 32'(dmem_we));
        end

        for (int i = 0; i < exp_name.size(); i++)
        begin
            wait_for_store(exp_name[i]);
            check_value({exp_name[i], "_addr"}, exp_addr[i], 32'(dmem_addr));
            check_value({exp_name[i], "_data"}, exp_data[i], dmem_wdata);
        end

        // program is parked in its self-loop now
        for (int n = 0; n < QUIET_CYCLES; n++)
        begin
            @(negedge clk);
            if (dmem_we)
                stop_with_failure($sformatf("unexpected store to word %0d after the final loop",
                                            dmem_addr));
        end

        $display("Everything OK");
        $finish;
    end

endmodule

/* src/cpu_top.sv */
module cpu_top (
    input  logic                             clk,
    input  logic                             rstn,
    output logic [cpu_pipe_pkg::XLEN-1:0]    imem_addr_o,
    input  logic [cpu_pipe_pkg::XLEN-1:0]    imem_data_i,
    output logic [cpu_pipe_pkg::DMEM_AW-1:0] dmem_addr_o,
    output logic [cpu_pipe_pkg::XLEN-1:0]    dmem_wdata_o,
    output logic                             dmem_we_o,
    input  logic [cpu_pipe_pkg::XLEN-1:0]    dmem_rdata_i
);

    // fetch / decode
    logic [cpu_pipe_pkg::XLEN-1:0]   if_id_pc;
    logic [cpu_pipe_pkg::XLEN-1:0]   if_id_instr;
    logic                            stall;
    logic                            branch_taken;
    logic [cpu_pipe_pkg::XLEN-1:0]   branch_target;
    logic [cpu_pipe_pkg::REG_AW-1:0] id_rs1;
    logic [cpu_pipe_pkg::REG_AW-1:0] id_rs2;
    logic [cpu_pipe_pkg::REG_AW-1:0] id_rd;
    logic [cpu_pipe_pkg::XLEN-1:0]   id_imm;
    cpu_isa_pkg::alu_op_e            id_alu_op;
    logic                            id_alu_src_imm;
    logic                            id_reg_write;
    logic                            id_mem_read;
    logic                            id_mem_write;
    logic                            id_uses_rs_early;
    logic [cpu_pipe_pkg::XLEN-1:0]   rf_rd1;
    logic [cpu_pipe_pkg::XLEN-1:0]   rf_rd2;
    logic [cpu_pipe_pkg::XLEN-1:0]   id_rs1_val;
    logic [cpu_pipe_pkg::XLEN-1:0]   id_rs2_val;
    cpu_pipe_pkg::fwd_sel_e          fwd_ex_a;
    cpu_pipe_pkg::fwd_sel_e          fwd_ex_b;
    cpu_pipe_pkg::fwd_sel_e          fwd_id_a;
    cpu_pipe_pkg::fwd_sel_e          fwd_id_b;
    // decode / execute
    logic                            id_ex_reg_write;
    logic                            id_ex_mem_read;
    logic                            id_ex_mem_write;
    logic [cpu_pipe_pkg::REG_AW-1:0] id_ex_rd;
    logic [cpu_pipe_pkg::REG_AW-1:0] id_ex_rs1;
    logic [cpu_pipe_pkg::REG_AW-1:0] id_ex_rs2;
    cpu_isa_pkg::alu_op_e            id_ex_alu_op;
    logic                            id_ex_alu_src_imm;
    logic [cpu_pipe_pkg::XLEN-1:0]   id_ex_imm;
    logic [cpu_pipe_pkg::XLEN-1:0]   id_ex_rs1_val;
    logic [cpu_pipe_pkg::XLEN-1:0]   id_ex_rs2_val;
    logic [cpu_pipe_pkg::XLEN-1:0]   ex_a;
    logic [cpu_pipe_pkg::XLEN-1:0]   ex_b_reg;
    logic [cpu_pipe_pkg::XLEN-1:0]   ex_b;
    logic [cpu_pipe_pkg::XLEN-1:0]   ex_y;
    // execute / memory, memory / writeback
    logic                            ex_mem_reg_write;
    logic                            ex_mem_mem_read;
    logic                            ex_mem_mem_write;
    logic [cpu_pipe_pkg::REG_AW-1:0] ex_mem_rd;
    logic [cpu_pipe_pkg::XLEN-1:0]   ex_mem_alu_y;
    logic [cpu_pipe_pkg::XLEN-1:0]   ex_mem_wdata;
    logic                            mem_wb_reg_write;
    logic                            mem_wb_mem_read;
    logic [cpu_pipe_pkg::REG_AW-1:0] mem_wb_rd;
    logic [cpu_pipe_pkg::XLEN-1:0]   mem_wb_alu_y;
    logic [cpu_pipe_pkg::XLEN-1:0]   mem_wb_rdata;
    logic [cpu_pipe_pkg::XLEN-1:0]   wb_data;

    function automatic logic [cpu_pipe_pkg::XLEN-1:0] fwd_mux(
        input cpu_pipe_pkg::fwd_sel_e        sel,
        input logic [cpu_pipe_pkg::XLEN-1:0] own,
        input logic [cpu_pipe_pkg::XLEN-1:0] from_mem,
        input logic [cpu_pipe_pkg::XLEN-1:0] from_wb
    );
        case (sel)
            cpu_pipe_pkg::FWD_EX_MEM: return from_mem;
            cpu_pipe_pkg::FWD_MEM_WB: return from_wb;
            default:                  return own;
        endcase
    endfunction

    fetch_stage u_fetch (
        .clk(clk), .rstn(rstn), .stall_i(stall),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .instr_i(imem_data_i), .pc_o(imem_addr_o),
        .if_id_pc_o(if_id_pc), .if_id_instr_o(if_id_instr)
    );

    decode_unit u_decode (
        .instr_i(if_id_instr), .pc_i(if_id_pc),
        .rs1_val_i(id_rs1_val), .rs2_val_i(id_rs2_val), .stall_i(stall),
        .rs1_o(id_rs1), .rs2_o(id_rs2), .rd_o(id_rd), .imm_o(id_imm),
        .alu_op_o(id_alu_op), .alu_src_imm_o(id_alu_src_imm),
        .reg_write_o(id_reg_write), .mem_read_o(id_mem_read), .mem_write_o(id_mem_write),
        .uses_rs_early_o(id_uses_rs_early),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target)
    );

    reg_file u_rf (
        .clk(clk), .rstn(rstn), .ra1_i(id_rs1), .ra2_i(id_rs2),
        .rd1_o(rf_rd1), .rd2_o(rf_rd2),
        .wa_i(mem_wb_rd), .wd_i(wb_data), .we_i(mem_wb_reg_write)
    );

    hazard_unit u_hazard (
        .id_rs1_i(id_rs1), .id_rs2_i(id_rs2), .id_uses_rs_early_i(id_uses_rs_early),
        .ex_rd_i(id_ex_rd), .ex_mem_read_i(id_ex_mem_read), .ex_reg_write_i(id_ex_reg_write),
        .ex_rs1_i(id_ex_rs1), .ex_rs2_i(id_ex_rs2),
        .mem_rd_i(ex_mem_rd), .mem_mem_read_i(ex_mem_mem_read),
        .mem_reg_write_i(ex_mem_reg_write),
        .wb_rd_i(mem_wb_rd), .wb_reg_write_i(mem_wb_reg_write),
        .stall_o(stall), .fwd_ex_a_o(fwd_ex_a), .fwd_ex_b_o(fwd_ex_b),
        .fwd_id_a_o(fwd_id_a), .fwd_id_b_o(fwd_id_b)
    );

    // also covers a write landing in the same cycle as decode
    assign id_rs1_val = fwd_mux(fwd_id_a, rf_rd1, ex_mem_alu_y, wb_data);
    assign id_rs2_val = fwd_mux(fwd_id_b, rf_rd2, ex_mem_alu_y, wb_data);

    ////////////////////////////////////////////////////////////
    // decode / execute register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            id_ex_reg_write <= 1'b0;
            id_ex_mem_read  <= 1'b0;
            id_ex_mem_write <= 1'b0;
            id_ex_rd        <= '0;
            id_ex_rs1       <= '0;
            id_ex_rs2       <= '0;
        end
        else
        begin
            id_ex_reg_write <= id_reg_write & ~stall;  // bubble on stall
            id_ex_mem_read  <= id_mem_read & ~stall;
            id_ex_mem_write <= id_mem_write & ~stall;
            id_ex_rd        <= stall ? '0 : id_rd;
            id_ex_rs1       <= stall ? '0 : id_rs1;
            id_ex_rs2       <= stall ? '0 : id_rs2;
        end
    end

    always_ff @(posedge clk)
    begin
        id_ex_alu_op      <= id_alu_op;
        id_ex_alu_src_imm <= id_alu_src_imm;
        id_ex_imm         <= id_imm;
        id_ex_rs1_val     <= id_rs1_val;
        id_ex_rs2_val     <= id_rs2_val;
    end

    assign ex_a     = fwd_mux(fwd_ex_a, id_ex_rs1_val, ex_mem_alu_y, wb_data);
    assign ex_b_reg = fwd_mux(fwd_ex_b, id_ex_rs2_val, ex_mem_alu_y, wb_data);
    assign ex_b     = id_ex_alu_src_imm ? id_ex_imm : ex_b_reg;

    alu u_alu (.a_i(ex_a), .b_i(ex_b), .op_i(id_ex_alu_op), .y_o(ex_y));

    ////////////////////////////////////////////////////////////
    // execute / memory and memory / writeback registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            ex_mem_reg_write <= 1'b0;
            ex_mem_mem_read  <= 1'b0;
            ex_mem_mem_write <= 1'b0;
            ex_mem_rd        <= '0;
            mem_wb_reg_write <= 1'b0;
            mem_wb_mem_read  <= 1'b0;
            mem_wb_rd        <= '0;
        end
        else
        begin
            ex_mem_reg_write <= id_ex_reg_write;
            ex_mem_mem_read  <= id_ex_mem_read;
            ex_mem_mem_write <= id_ex_mem_write;
            ex_mem_rd        <= id_ex_rd;
            mem_wb_reg_write <= ex_mem_reg_write;
            mem_wb_mem_read  <= ex_mem_mem_read;
            mem_wb_rd        <= ex_mem_rd;
        end
    end

    always_ff @(posedge clk)
    begin
        ex_mem_alu_y <= ex_y;
        ex_mem_wdata <= ex_b_reg;  // forwarded store data
        mem_wb_alu_y <= ex_mem_alu_y;
        mem_wb_rdata <= dmem_rdata_i;
    end

    assign dmem_addr_o  = ex_mem_alu_y[cpu_pipe_pkg::DMEM_AW+1:2];  // byte to word address
    assign dmem_wdata_o = ex_mem_wdata;
    assign dmem_we_o    = ex_mem_mem_write;
    assign wb_data      = mem_wb_mem_read ? mem_wb_rdata : mem_wb_alu_y;

    // load data is only available from writeback, the stalls must keep it that way
    fwd_from_mem_a: assert property (@(posedge clk) disable iff (!rstn)
        (fwd_ex_a == cpu_pipe_pkg::FWD_EX_MEM || fwd_ex_b == cpu_pipe_pkg::FWD_EX_MEM
         || (id_uses_rs_early && !stall && (fwd_id_a == cpu_pipe_pkg::FWD_EX_MEM
                                           || fwd_id_b == cpu_pipe_pkg::FWD_EX_MEM)))
        |-> (ex_mem_reg_write && !ex_mem_mem_read));

endmodule

/* src/hazard_unit.sv */
module hazard_unit (
    input  logic [cpu_pipe_pkg::REG_AW-1:0] id_rs1_i,
    input  logic [cpu_pipe_pkg::REG_AW-1:0] id_rs2_i,
    input  logic                            id_uses_rs_early_i,
    input  logic [cpu_pipe_pkg::REG_AW-1:0] ex_rd_i,
    input  logic                            ex_mem_read_i,
    input  logic                            ex_reg_write_i,
    input  logic [cpu_pipe_pkg::REG_AW-1:0] ex_rs1_i,
    input  logic [cpu_pipe_pkg::REG_AW-1:0] ex_rs2_i,
    input  logic [cpu_pipe_pkg::REG_AW-1:0] mem_rd_i,
    input  logic                            mem_mem_read_i,
    input  logic                            mem_reg_write_i,
    input  logic [cpu_pipe_pkg::REG_AW-1:0] wb_rd_i,
    input  logic                            wb_reg_write_i,
    output logic                            stall_o,
    output cpu_pipe_pkg::fwd_sel_e          fwd_ex_a_o,
    output cpu_pipe_pkg::fwd_sel_e          fwd_ex_b_o,
    output cpu_pipe_pkg::fwd_sel_e          fwd_id_a_o,
    output cpu_pipe_pkg::fwd_sel_e          fwd_id_b_o
);

    logic id_hit_ex;
    logic id_hit_mem;

    function automatic logic hit(input logic [cpu_pipe_pkg::REG_AW-1:0] rd,
                                 input logic [cpu_pipe_pkg::REG_AW-1:0] rs);
        return (rd != '0) && (rd == rs);
    endfunction

    // nearest producer wins
    function automatic cpu_pipe_pkg::fwd_sel_e pick(input logic [cpu_pipe_pkg::REG_AW-1:0] rs);
        if (mem_reg_write_i && hit(mem_rd_i, rs))
            return cpu_pipe_pkg::FWD_EX_MEM;
        if (wb_reg_write_i && hit(wb_rd_i, rs))
            return cpu_pipe_pkg::FWD_MEM_WB;
        return cpu_pipe_pkg::FWD_NONE;
    endfunction

    assign id_hit_ex  = hit(ex_rd_i, id_rs1_i) || hit(ex_rd_i, id_rs2_i);
    assign id_hit_mem = hit(mem_rd_i, id_rs1_i) || hit(mem_rd_i, id_rs2_i);

    assign stall_o = (ex_mem_read_i && id_hit_ex)                         // load-use
                   || (id_uses_rs_early_i && ex_reg_write_i && id_hit_ex)  // branch on ex result
                   || (id_uses_rs_early_i && mem_mem_read_i && id_hit_mem); // load still in mem

    always_comb
    begin
        fwd_ex_a_o = pick(ex_rs1_i);
        fwd_ex_b_o = pick(ex_rs2_i);
        fwd_id_a_o = pick(id_rs1_i);
        fwd_id_b_o = pick(id_rs2_i);
    end

endmodule

/* src/decode_unit.sv */
module decode_unit (
    input  logic [cpu_pipe_pkg::XLEN-1:0]   instr_i,
    input  logic [cpu_pipe_pkg::XLEN-1:0]   pc_i,
    input  logic [cpu_pipe_pkg::XLEN-1:0]   rs1_val_i,
    input  logic [cpu_pipe_pkg::XLEN-1:0]   rs2_val_i,
    input  logic                            stall_i,
    output logic [cpu_pipe_pkg::REG_AW-1:0] rs1_o,
    output logic [cpu_pipe_pkg::REG_AW-1:0] rs2_o,
    output logic [cpu_pipe_pkg::REG_AW-1:0] rd_o,
    output logic [cpu_pipe_pkg::XLEN-1:0]   imm_o,
    output cpu_isa_pkg::alu_op_e            alu_op_o,
    output logic                            alu_src_imm_o,
    output logic                            reg_write_o,
    output logic                            mem_read_o,
    output logic                            mem_write_o,
    output logic                            uses_rs_early_o,
    output logic                            branch_taken_o,
    output logic [cpu_pipe_pkg::XLEN-1:0]   branch_target_o
);

    logic [2:0]                    funct3;
    logic                          alt;
    logic                          use_rs1;
    logic                          use_rs2;
    logic                          is_branch;
    logic                          cond_ok;
    logic                          cond_true;
    cpu_isa_pkg::branch_cond_e     cond;
    logic [cpu_pipe_pkg::XLEN-1:0] imm_i;
    logic [cpu_pipe_pkg::XLEN-1:0] imm_s;
    logic [cpu_pipe_pkg::XLEN-1:0] imm_b;

    assign funct3 = instr_i[14:12];
    assign alt    = (instr_i[31:25] == cpu_isa_pkg::FUNCT7_ALT);
    assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b  = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};

    // unused register fields read as x0 so they never stall or forward
    assign rs1_o = use_rs1 ? instr_i[19:15] : '0;
    assign rs2_o = use_rs2 ? instr_i[24:20] : '0;
    assign rd_o  = reg_write_o ? instr_i[11:7] : '0;

    always_comb
    begin
        use_rs1       = 1'b0;
        use_rs2       = 1'b0;
        is_branch     = 1'b0;
        imm_o         = imm_i;
        alu_op_o      = cpu_isa_pkg::ALU_ADD;
        alu_src_imm_o = 1'b0;
        reg_write_o   = 1'b0;
        mem_read_o    = 1'b0;
        mem_write_o   = 1'b0;
        case (cpu_isa_pkg::opcode_e'(instr_i[6:0]))
            cpu_isa_pkg::OPC_OP:
            begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                reg_write_o = 1'b1;
                case (funct3)
                    cpu_isa_pkg::FUNCT3_ADD_SUB:
                        alu_op_o = alt ? cpu_isa_pkg::ALU_SUB : cpu_isa_pkg::ALU_ADD;
                    cpu_isa_pkg::FUNCT3_SLL: alu_op_o = cpu_isa_pkg::ALU_SLL;
                    cpu_isa_pkg::FUNCT3_XOR: alu_op_o = cpu_isa_pkg::ALU_XOR;
                    cpu_isa_pkg::FUNCT3_SR:
                        alu_op_o = alt ? cpu_isa_pkg::ALU_SRA : cpu_isa_pkg::ALU_SRL;
                    cpu_isa_pkg::FUNCT3_OR:  alu_op_o = cpu_isa_pkg::ALU_OR;
                    cpu_isa_pkg::FUNCT3_AND: alu_op_o = cpu_isa_pkg::ALU_AND;
                    default:                 reg_write_o = 1'b0;  // slt/sltu not kept
                endcase
            end
            cpu_isa_pkg::OPC_OP_IMM:
            begin
                use_rs1       = 1'b1;
                alu_src_imm_o = 1'b1;
                reg_write_o   = 1'b1;
                case (funct3)
                    cpu_isa_pkg::FUNCT3_ADD_SUB: alu_op_o = cpu_isa_pkg::ALU_ADD;
                    cpu_isa_pkg::FUNCT3_XOR:     alu_op_o = cpu_isa_pkg::ALU_XOR;
                    cpu_isa_pkg::FUNCT3_OR:      alu_op_o = cpu_isa_pkg::ALU_OR;
                    cpu_isa_pkg::FUNCT3_AND:     alu_op_o = cpu_isa_pkg::ALU_AND;
                    default:                     reg_write_o = 1'b0;
                endcase
            end
            cpu_isa_pkg::OPC_LOAD:
            begin
                use_rs1       = (funct3 == cpu_isa_pkg::FUNCT3_WORD);
                alu_src_imm_o = 1'b1;
                reg_write_o   = use_rs1;
                mem_read_o    = use_rs1;  // lw only
            end
            cpu_isa_pkg::OPC_STORE:
            begin
                use_rs1       = (funct3 == cpu_isa_pkg::FUNCT3_WORD);
                use_rs2       = use_rs1;
                imm_o         = imm_s;
                alu_src_imm_o = 1'b1;
                mem_write_o   = use_rs1;
            end
            cpu_isa_pkg::OPC_BRANCH:
            begin
                use_rs1   = cond_ok;
                use_rs2   = cond_ok;
                imm_o     = imm_b;
                is_branch = cond_ok;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // branch resolution
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        cond_ok = 1'b1;
        case (funct3)
            cpu_isa_pkg::FUNCT3_BEQ: cond = cpu_isa_pkg::BR_EQ;
            cpu_isa_pkg::FUNCT3_BNE: cond = cpu_isa_pkg::BR_NE;
            cpu_isa_pkg::FUNCT3_BLT: cond = cpu_isa_pkg::BR_LT;
            cpu_isa_pkg::FUNCT3_BGE: cond = cpu_isa_pkg::BR_GE;
            default:
            begin
                cond    = cpu_isa_pkg::BR_EQ;
                cond_ok = 1'b0;  // bltu/bgeu dropped
            end
        endcase
        case (cond)
            cpu_isa_pkg::BR_EQ: cond_true = (rs1_val_i == rs2_val_i);
            cpu_isa_pkg::BR_NE: cond_true = (rs1_val_i != rs2_val_i);
            cpu_isa_pkg::BR_LT: cond_true = ($signed(rs1_val_i) < $signed(rs2_val_i));
            default:            cond_true = ($signed(rs1_val_i) >= $signed(rs2_val_i));
        endcase
    end

    assign uses_rs_early_o = is_branch;
    assign branch_taken_o  = is_branch & cond_true & ~stall_i;  // operands not ready yet
    assign branch_target_o = pc_i + imm_b;

endmodule

/* src/fetch_stage.sv */
module fetch_stage (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          stall_i,
    input  logic                          branch_taken_i,
    input  logic [cpu_pipe_pkg::XLEN-1:0] branch_target_i,
    input  logic [cpu_pipe_pkg::XLEN-1:0] instr_i,
    output logic [cpu_pipe_pkg::XLEN-1:0] pc_o,
    output logic [cpu_pipe_pkg::XLEN-1:0] if_id_pc_o,
    output logic [cpu_pipe_pkg::XLEN-1:0] if_id_instr_o
);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            pc_o <= cpu_pipe_pkg::RESET_PC;
        else if (branch_taken_i)
            pc_o <= branch_target_i;  // resolved in decode
        else if (!stall_i)
            pc_o <= pc_o + cpu_pipe_pkg::XLEN'(4);
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            if_id_pc_o    <= '0;
            if_id_instr_o <= '0;
        end
        else if (branch_taken_i)
        begin
            if_id_pc_o    <= '0;
            if_id_instr_o <= '0;  // squash the wrong-path fetch
        end
        else if (!stall_i)
        begin
            if_id_pc_o    <= pc_o;
            if_id_instr_o <= instr_i;
        end
    end

    // branch offsets only guarantee 2-byte alignment
    pc_aligned_a: assert property (@(posedge clk) disable iff (!rstn) pc_o[1:0] == 2'b00);

endmodule

/* src/reg_file.sv */
module reg_file (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [cpu_pipe_pkg::REG_AW-1:0] ra1_i,
    input  logic [cpu_pipe_pkg::REG_AW-1:0] ra2_i,
    output logic [cpu_pipe_pkg::XLEN-1:0]   rd1_o,
    output logic [cpu_pipe_pkg::XLEN-1:0]   rd2_o,
    input  logic [cpu_pipe_pkg::REG_AW-1:0] wa_i,
    input  logic [cpu_pipe_pkg::XLEN-1:0]   wd_i,
    input  logic                            we_i
);

    logic [cpu_pipe_pkg::XLEN-1:0] regs [1 << cpu_pipe_pkg::REG_AW];

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < (1 << cpu_pipe_pkg::REG_AW); i++)
                regs[i] <= '0;
        end
        else if (we_i && wa_i != '0)
            regs[wa_i] <= wd_i;  // x0 never written
    end

    assign rd1_o = regs[ra1_i];
    assign rd2_o = regs[ra2_i];

    x0_zero_a: assert property (@(posedge clk) disable iff (!rstn)
        (ra1_i != '0 || rd1_o == '0) && (ra2_i != '0 || rd2_o == '0));

endmodule

/* src/alu.sv */
module alu (
    input  logic [31:0]          a_i,
    input  logic [31:0]          b_i,
    input  cpu_isa_pkg::alu_op_e op_i,
    output logic [31:0]          y_o
);

    always_comb
    begin
        case (op_i)
            cpu_isa_pkg::ALU_ADD: y_o = a_i + b_i;
            cpu_isa_pkg::ALU_SUB: y_o = a_i - b_i;
            cpu_isa_pkg::ALU_AND: y_o = a_i & b_i;
            cpu_isa_pkg::ALU_OR:  y_o = a_i | b_i;
            cpu_isa_pkg::ALU_XOR: y_o = a_i ^ b_i;
            cpu_isa_pkg::ALU_SLL: y_o = a_i << b_i[4:0];
            cpu_isa_pkg::ALU_SRL: y_o = a_i >> b_i[4:0];
            cpu_isa_pkg::ALU_SRA: y_o = $signed(a_i) >>> b_i[4:0];  // sign fill
            default:              y_o = a_i + b_i;
        endcase
    end

endmodule

/* src/cpu_pipe_pkg.sv */
package cpu_pipe_pkg;

    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;
    localparam int DMEM_AW = 15;  // data memory word address

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // operand source for the forwarding muxes
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_e;

endpackage

/* src/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE
    } branch_cond_e;

    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_WORD    = 3'b010;  // lw / sw width
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SR      = 3'b101;  // srl / sra
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;
    localparam logic [2:0] FUNCT3_BEQ     = 3'b000;
    localparam logic [2:0] FUNCT3_BNE     = 3'b001;
    localparam logic [2:0] FUNCT3_BLT     = 3'b100;
    localparam logic [2:0] FUNCT3_BGE     = 3'b101;
    localparam logic [6:0] FUNCT7_ALT     = 7'b0100000;  // sub, sra

endpackage
